//--- Bender.yml
package:
  name: cpu_core

sources:
  # packages first, then the units and the core top
  - hw/cpu_types_pkg.sv
  - hw/isa_pkg.sv
  - hw/instr_decode.sv
  - hw/cpu_control.sv
  - hw/cpu_datapath.sv
  - hw/cpu_core.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_cpu_core.sv

//--- hw/cpu_control.sv
// ======================================================================
// Control sequencer of the core
// Runs the fetch, immediate-operand and store bus cycles over the
// DIN/DOUT/RPLY handshake and strobes datapath commands each cycle
// ======================================================================

module cpu_control (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              ce_i,
    input  isa_pkg::decoded_t decoded_i,
    input  logic              branch_taken_i,
    input  logic              rply_i,
    output isa_pkg::dp_cmd_t  cmd_o,
    output logic              din_o,
    output logic              dout_o,
    output logic              ifetch_o,
    output logic              init_req_o,
    output logic              halt_o
);
    import isa_pkg::*;

    typedef enum logic [2:0] {
        FETCH,
        SRC_IMM,
        EXEC,
        WRITE,
        HALTED
    } state_e;

    state_e state_q;
    logic   is_alu;
    logic   is_branch;
    logic   bus_done;

    assign is_alu    = decoded_i.op inside {OP_MOV, OP_ADD, OP_SUB, OP_CMP};
    assign is_branch = decoded_i.op inside {OP_BR, OP_BNE, OP_BEQ};
    assign bus_done  = (din_o || dout_o) && rply_i;   // reply ends the cycle

    // ==================================================================
    // state and bus strobes
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q  <= FETCH;
            din_o    <= 1'b0;
            dout_o   <= 1'b0;
            ifetch_o <= 1'b0;
            halt_o   <= 1'b0;
        end else if (ce_i) begin
            case (state_q)
                FETCH: begin
                    if (!din_o) begin
                        din_o    <= 1'b1;    // address latched this edge
                        ifetch_o <= 1'b1;
                    end else if (bus_done) begin
                        din_o    <= 1'b0;
                        ifetch_o <= 1'b0;
                        state_q  <= SRC_IMM;
                    end
                end
                SRC_IMM: begin
                    if (!decoded_i.src_imm) begin
                        state_q <= EXEC;
                    end else if (!din_o) begin
                        din_o <= 1'b1;       // read the word after the opcode
                    end else if (bus_done) begin
                        din_o   <= 1'b0;
                        state_q <= EXEC;
                    end
                end
                EXEC: begin
                    if (decoded_i.op == OP_HALT) begin
                        halt_o  <= 1'b1;
                        state_q <= HALTED;
                    end else if (is_alu && decoded_i.dst_deferred) begin
                        dout_o  <= 1'b1;
                        state_q <= WRITE;
                    end else begin
                        state_q <= FETCH;
                    end
                end
                WRITE: begin
                    if (bus_done) begin
                        dout_o  <= 1'b0;
                        state_q <= FETCH;
                    end
                end
                HALTED: state_q <= HALTED;   // only reset leaves
                default: state_q <= FETCH;
            endcase
        end
    end

    // ==================================================================
    // datapath strobes, taken by the datapath only on enabled edges
    // ==================================================================
    always_comb begin
        cmd_o      = '0;
        init_req_o = 1'b0;
        case (state_q)
            FETCH: begin
                cmd_o.addr_from_pc = !din_o;
                cmd_o.load_ir      = bus_done;
                cmd_o.pc_inc       = bus_done;
            end
            SRC_IMM: begin
                if (!decoded_i.src_imm) begin
                    cmd_o.src_from_reg = 1'b1;
                end else begin
                    cmd_o.addr_from_src = !din_o;   // src reg is R7 here
                    cmd_o.src_from_bus  = bus_done;
                    cmd_o.pc_inc        = bus_done;
                end
            end
            EXEC: begin
                cmd_o.alu_exec      = is_alu;
                cmd_o.dst_write     = is_alu && !decoded_i.dst_deferred &&
                                      decoded_i.op != OP_CMP;
                cmd_o.wdata_latch   = is_alu && decoded_i.dst_deferred;
                cmd_o.addr_from_dst = is_alu && decoded_i.dst_deferred;
                cmd_o.branch        = is_branch && branch_taken_i;
                init_req_o          = (decoded_i.op == OP_RESET);
            end
            default: cmd_o = '0;
        endcase
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(din_o && dout_o));

    // a strobe only drops on an enabled edge with the reply present
    a_strobe_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        (din_o || dout_o) && !(ce_i && rply_i) |=> $stable({din_o, dout_o}));

endmodule

//--- hw/cpu_core.sv
// ======================================================================
// Core top: sequencer, decoder and datapath on the DIN/DOUT/RPLY bus
// Also stretches the RESET instruction into the peripheral INIT pulse
// ======================================================================

module cpu_core #(
    parameter cpu_types_pkg::word_t BOOT_ADDR   = 16'o100000,
    parameter int unsigned          INIT_CYCLES = 10
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 ce_i,
    input  logic                 rply_i,
    input  cpu_types_pkg::word_t data_i,
    output cpu_types_pkg::word_t addr_o,
    output cpu_types_pkg::word_t data_o,
    output logic                 din_o,
    output logic                 dout_o,
    output logic                 ifetch_o,
    output logic                 init_o,
    output logic                 halt_o
);
    import cpu_types_pkg::*;
    import isa_pkg::*;

    localparam int unsigned CNT_W = $clog2(INIT_CYCLES + 1);

    decoded_t         decoded;
    dp_cmd_t          cmd;
    word_t            opcode;
    logic             branch_taken;
    logic             init_req;
    logic [CNT_W-1:0] init_cnt_q;

    cpu_control control_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ce_i           (ce_i),
        .decoded_i      (decoded),
        .branch_taken_i (branch_taken),
        .rply_i         (rply_i),
        .cmd_o          (cmd),
        .din_o          (din_o),
        .dout_o         (dout_o),
        .ifetch_o       (ifetch_o),
        .init_req_o     (init_req),
        .halt_o         (halt_o)
    );

    instr_decode decode_i (
        .opcode_i  (opcode),
        .decoded_o (decoded)
    );

    cpu_datapath #(
        .BOOT_ADDR (BOOT_ADDR)
    ) datapath_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .ce_i           (ce_i),
        .cmd_i          (cmd),
        .decoded_i      (decoded),
        .data_i         (data_i),
        .opcode_o       (opcode),
        .addr_o         (addr_o),
        .data_o         (data_o),
        .branch_taken_o (branch_taken)
    );

    // INIT stretcher, counts enabled cycles only
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            init_cnt_q <= '0;
        end else if (ce_i) begin
            if (init_req) begin
                init_cnt_q <= CNT_W'(INIT_CYCLES);
            end else if (init_cnt_q != '0) begin
                init_cnt_q <= init_cnt_q - 1'b1;
            end
        end
    end

    assign init_o = (init_cnt_q != '0);

endmodule

//--- hw/cpu_datapath.sv
// ======================================================================
// Datapath of the core
// R0-R6, PC, instruction register, source latch, ALU with PSW flags,
// branch evaluation and the bus address and write data registers
// ======================================================================

module cpu_datapath #(
    parameter cpu_types_pkg::word_t BOOT_ADDR = 16'o100000
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 ce_i,
    input  isa_pkg::dp_cmd_t     cmd_i,
    input  isa_pkg::decoded_t    decoded_i,
    input  cpu_types_pkg::word_t data_i,
    output cpu_types_pkg::word_t opcode_o,
    output cpu_types_pkg::word_t addr_o,
    output cpu_types_pkg::word_t data_o,
    output logic                 branch_taken_o
);
    import cpu_types_pkg::*;
    import isa_pkg::*;

    localparam int unsigned MSB = WORD_W - 1;

    word_t gpr [0:PC_REG-1];     // R0-R6
    word_t pc_q;
    word_t ir_q;
    word_t src_q;                // source operand latch
    word_t addr_q;
    word_t wdata_q;
    psw_t  psw_q;

    word_t src_val;
    word_t dst_val;
    word_t alu_res;
    psw_t  alu_flags;
    logic [WORD_W:0] sum_ext;    // carry or borrow in the top bit
    word_t br_disp;

    assign src_val = (decoded_i.src_reg == PC_REG) ? pc_q : gpr[decoded_i.src_reg];
    assign dst_val = (decoded_i.dst_reg == PC_REG) ? pc_q : gpr[decoded_i.dst_reg];

    assign br_disp = {{(WORD_W-9){decoded_i.br_offset[7]}}, decoded_i.br_offset, 1'b0};

    // ==================================================================
    // ALU and flags
    // ==================================================================
    always_comb begin
        alu_res   = src_q;
        alu_flags = psw_q;
        sum_ext   = '0;
        case (decoded_i.op)
            OP_ADD: begin
                sum_ext     = {1'b0, dst_val} + {1'b0, src_q};
                alu_flags.v = (src_q[MSB] == dst_val[MSB]) && (sum_ext[MSB] != src_q[MSB]);
            end
            OP_SUB: begin
                sum_ext     = {1'b0, dst_val} - {1'b0, src_q};
                alu_flags.v = (src_q[MSB] != dst_val[MSB]) && (sum_ext[MSB] == src_q[MSB]);
            end
            OP_CMP: begin
                sum_ext     = {1'b0, src_q} - {1'b0, dst_val};   // src - dst
                alu_flags.v = (src_q[MSB] != dst_val[MSB]) && (sum_ext[MSB] == dst_val[MSB]);
            end
            default: alu_flags.v = 1'b0;   // MOV, C kept
        endcase
        if (decoded_i.op inside {OP_ADD, OP_SUB, OP_CMP}) begin
            alu_res     = sum_ext[MSB:0];
            alu_flags.c = sum_ext[WORD_W];
        end
        alu_flags.n = alu_res[MSB];
        alu_flags.z = (alu_res == '0);
    end

    always_comb begin
        case (decoded_i.op)
            OP_BR:   branch_taken_o = 1'b1;
            OP_BNE:  branch_taken_o = !psw_q.z;
            OP_BEQ:  branch_taken_o = psw_q.z;
            default: branch_taken_o = 1'b0;
        endcase
    end

    // ==================================================================
    // PC and flags
    // ==================================================================
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q  <= BOOT_ADDR;
            psw_q <= '0;
        end else if (ce_i) begin
            if (cmd_i.pc_inc) begin
                pc_q <= pc_q + word_t'(2);
            end else if (cmd_i.branch) begin
                pc_q <= pc_q + br_disp;      // offset counts words
            end
            if (cmd_i.alu_exec) begin
                psw_q <= alu_flags;
            end
        end
    end

    // registers and bus latches
    always_ff @(posedge clk) begin
        if (ce_i) begin
            if (cmd_i.load_ir) begin
                ir_q <= data_i;
            end
            if (cmd_i.src_from_reg) begin
                src_q <= src_val;
            end else if (cmd_i.src_from_bus) begin
                src_q <= data_i;             // immediate word
            end
            if (cmd_i.addr_from_pc) begin
                addr_q <= pc_q;
            end else if (cmd_i.addr_from_src) begin
                addr_q <= src_val;
            end else if (cmd_i.addr_from_dst) begin
                addr_q <= dst_val;
            end
            if (cmd_i.wdata_latch) begin
                wdata_q <= alu_res;
            end
            if (cmd_i.dst_write && decoded_i.dst_reg != PC_REG) begin
                gpr[decoded_i.dst_reg] <= alu_res;
            end
        end
    end

    assign opcode_o = ir_q;
    assign addr_o   = addr_q;
    assign data_o   = wdata_q;

    a_pc_even: assert property (@(posedge clk) disable iff (!rst_n_i) !pc_q[0]);

endmodule

//--- hw/cpu_types_pkg.sv
// ======================================================================
// Machine word types shared by every unit of the core
// Word, register number and PSW flag definitions, plus the bus width
// ======================================================================

package cpu_types_pkg;

    localparam int unsigned WORD_W    = 16;    // data and address bus width
    localparam int unsigned REG_IDX_W = 3;     // eight general registers

    typedef logic [WORD_W-1:0]    word_t;      // data word, also bus address
    typedef logic [REG_IDX_W-1:0] reg_idx_t;   // register number

    localparam reg_idx_t PC_REG = 3'd7;        // R7 is the program counter

    // condition codes, same order as PSW bits 3..0
    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } psw_t;

endpackage

//--- hw/instr_decode.sv
// ======================================================================
// Combinational instruction decoder
// Maps the instruction register onto a decoded_t; anything outside
// the supported subset comes out as OP_NOP
// ======================================================================

module instr_decode (
    input  cpu_types_pkg::word_t opcode_i,
    output isa_pkg::decoded_t    decoded_o
);
    import cpu_types_pkg::*;
    import isa_pkg::*;

    logic [2:0] src_mode;
    logic [2:0] dst_mode;
    op_class_e  dop_class;
    logic       src_ok;
    logic       dst_ok;

    assign src_mode = opcode_i[11:9];
    assign dst_mode = opcode_i[5:3];

    always_comb begin
        decoded_o           = '0;
        decoded_o.op        = OP_NOP;
        decoded_o.src_reg   = opcode_i[8:6];
        decoded_o.dst_reg   = opcode_i[2:0];
        decoded_o.br_offset = opcode_i[7:0];

        case (opcode_i[15:12])
            OPC_MOV: dop_class = OP_MOV;
            OPC_CMP: dop_class = OP_CMP;
            OPC_ADD: dop_class = OP_ADD;
            OPC_SUB: dop_class = OP_SUB;
            default: dop_class = OP_NOP;
        endcase

        // source is Rn or the immediate (R7)+
        src_ok = (src_mode == MODE_REG) ||
                 (src_mode == MODE_AUTOINC && opcode_i[8:6] == PC_REG);

        // no PC destination; @Rn only as a MOV store, there is no
        // read-modify-write cycle in this core
        dst_ok = (opcode_i[2:0] != PC_REG) &&
                 ((dst_mode == MODE_REG) ||
                  (dst_mode == MODE_DEF && dop_class == OP_MOV));

        if (dop_class != OP_NOP) begin
            if (src_ok && dst_ok) begin
                decoded_o.op           = dop_class;
                decoded_o.src_imm      = (src_mode == MODE_AUTOINC);
                decoded_o.dst_deferred = (dst_mode == MODE_DEF);
            end
        end else if (opcode_i[15:8] == BR_HI) begin
            decoded_o.op = OP_BR;
        end else if (opcode_i[15:8] == BNE_HI) begin
            decoded_o.op = OP_BNE;
        end else if (opcode_i[15:8] == BEQ_HI) begin
            decoded_o.op = OP_BEQ;
        end else if (opcode_i == HALT_WORD) begin
            decoded_o.op = OP_HALT;
        end else if (opcode_i == RESET_WORD) begin
            decoded_o.op = OP_RESET;
        end
    end

endmodule

//--- hw/isa_pkg.sv
// ======================================================================
// Instruction set definitions for the reduced PDP-11 style core
// Opcode fields, instruction classes, decoded instruction and the
// one-cycle command strobes from the sequencer to the datapath
// ======================================================================

package isa_pkg;

    // double-operand opcodes, bits 15..12
    localparam logic [3:0] OPC_MOV = 4'b0001;
    localparam logic [3:0] OPC_CMP = 4'b0010;
    localparam logic [3:0] OPC_ADD = 4'b0110;
    localparam logic [3:0] OPC_SUB = 4'b1110;

    // branch high bytes, bits 15..8
    localparam logic [7:0] BR_HI  = 8'o001;
    localparam logic [7:0] BNE_HI = 8'o002;
    localparam logic [7:0] BEQ_HI = 8'o003;

    localparam logic [15:0] HALT_WORD  = 16'o000000;
    localparam logic [15:0] RESET_WORD = 16'o000005;

    // addressing modes
    localparam logic [2:0] MODE_REG     = 3'd0;
    localparam logic [2:0] MODE_DEF     = 3'd1;
    localparam logic [2:0] MODE_AUTOINC = 3'd2;

    typedef enum logic [3:0] {
        OP_MOV, OP_ADD, OP_SUB, OP_CMP,
        OP_BR, OP_BNE, OP_BEQ,
        OP_RESET, OP_HALT, OP_NOP
    } op_class_e;

    typedef struct packed {
        op_class_e               op;
        cpu_types_pkg::reg_idx_t src_reg;
        logic                    src_imm;       // (R7)+ immediate word
        cpu_types_pkg::reg_idx_t dst_reg;
        logic                    dst_deferred;  // @Rn store
        logic signed [7:0]       br_offset;     // in words
    } decoded_t;

    typedef struct packed {
        logic load_ir;
        logic pc_inc;
        logic addr_from_pc;
        logic addr_from_src;
        logic addr_from_dst;
        logic src_from_reg;
        logic src_from_bus;
        logic alu_exec;
        logic dst_write;
        logic wdata_latch;
        logic branch;
    } dp_cmd_t;

endpackage

//--- sources.f
+incdir+testbench
hw/cpu_types_pkg.sv
hw/isa_pkg.sv
hw/instr_decode.sv
hw/cpu_control.sv
hw/cpu_datapath.sv
hw/cpu_core.sv
testbench/tb_cpu_core.sv

//--- testbench/cpu_ref_model.svh
// ======================================================================
// Reference side of the core testbench: LFSR, random program generator
// and an instruction-level model listing the bus cycles the core makes
// Included inside the testbench module, shares its memory and queues
// ======================================================================

// PDP-11 encodings of the tested subset
localparam word_t MOV_OP   = 16'o010000;
localparam word_t CMP_OP   = 16'o020000;
localparam word_t ADD_OP   = 16'o060000;
localparam word_t SUB_OP   = 16'o160000;
localparam word_t BR_OP    = 16'o000400;
localparam word_t BNE_OP   = 16'o001000;
localparam word_t BEQ_OP   = 16'o001400;
localparam word_t HALT_OP  = 16'o000000;
localparam word_t RESET_OP = 16'o000005;

localparam word_t DATA_BASE  = BOOT_ADDR + 16'o600;   // word 192, past the code
localparam int    BODY_INSTR = 54;
localparam int    RESET_AT   = 30;

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        val    = {val[30:0], lfsr_q[0]};   // one step per bit
    end
    return val;
endfunction

function automatic logic [7:0] word_index(input word_t addr);
    word_t offs;
    offs = addr - BOOT_ADDR;
    return offs[8:1];
endfunction

function automatic word_t dop(input word_t base, input logic [2:0] sm, input logic [2:0] sr,
                              input logic [2:0] dm, input logic [2:0] dr);
    return base | {4'b0, sm, sr, dm, dr};
endfunction

function automatic void put_word(input word_t w);
    mem[wr_idx] = w;
    wr_idx++;
endfunction

function automatic logic [2:0] src_pick();
    logic [2:0] s;
    s = 3'(take_bits(3));
    return (s > 3'd4) ? s - 3'd4 : s;   // R0-R4 only, all loaded
endfunction

function automatic void emit_alu(input logic allow_imm);
    word_t base;
    case (take_bits(2))
        0:       base = MOV_OP;
        1:       base = ADD_OP;
        2:       base = SUB_OP;
        default: base = CMP_OP;
    endcase
    if (allow_imm && take_bits(2) == 0) begin
        put_word(dop(base, 3'd2, 3'd7, 3'd0, 3'(take_bits(2))));
        put_word(word_t'(take_bits(16)));
    end else begin
        put_word(dop(base, 3'd0, src_pick(), 3'd0, 3'(take_bits(2))));
    end
    n_instr++;
endfunction

function automatic void emit_store(input logic allow_imm);
    if (allow_imm && take_bits(2) == 0) begin
        put_word(dop(MOV_OP, 3'd2, 3'd7, 3'd1, 3'd4));   // MOV #n, @R4
        put_word(word_t'(take_bits(16)));
    end else begin
        put_word(dop(MOV_OP, 3'd0, src_pick(), 3'd1, 3'd4));
    end
    n_instr++;
endfunction

// ======================================================================
// program: load R4 and R0-R3, random body with one RESET, final HALT
// ======================================================================
function automatic void gen_program();
    int         skip_left;
    logic       reset_placed;
    logic [2:0] sel;
    logic [1:0] k;
    word_t      a;
    for (int i = 0; i < 256; i++) begin
        a      = BOOT_ADDR + word_t'(2 * i);
        mem[i] = {a[7:0], a[15:8]} ^ 16'h5a3c;
    end
    wr_idx       = 0;
    n_instr      = 1;
    skip_left    = 0;
    reset_placed = 1'b0;
    put_word(dop(MOV_OP, 3'd2, 3'd7, 3'd0, 3'd4));
    put_word(DATA_BASE);
    for (int r = 0; r < 4; r++) begin
        put_word(dop(MOV_OP, 3'd2, 3'd7, 3'd0, 3'(r)));
        put_word(word_t'(take_bits(16)));
        n_instr++;
    end
    for (int i = 0; i < BODY_INSTR || skip_left != 0; i++) begin
        if (skip_left != 0) begin
            // single words only, so branch targets hit opcodes
            if (take_bits(1) != 0) emit_store(1'b0);
            else emit_alu(1'b0);
            skip_left--;
        end else if (!reset_placed && i >= RESET_AT) begin
            put_word(RESET_OP);
            n_instr++;
            reset_placed = 1'b1;
        end else begin
            sel = 3'(take_bits(3));
            if (sel >= 3'd6) begin
                k = 2'(take_bits(2));
                case (take_bits(2))
                    0:       put_word(BR_OP | word_t'(k));
                    1:       put_word(BNE_OP | word_t'(k));
                    default: put_word(BEQ_OP | word_t'(k));
                endcase
                n_instr++;
                skip_left = k;
            end else if (sel >= 3'd4) begin
                emit_store(1'b1);
            end else begin
                emit_alu(1'b1);
            end
        end
    end
    put_word(HALT_OP);
    n_instr++;
endfunction

function automatic void add_event(input logic [1:0] kind, input logic is_rst,
                                  input word_t addr, input word_t data);
    bus_evt_t ev;
    ev.kind     = kind;
    ev.is_reset = is_rst;
    ev.addr     = addr;
    ev.data     = data;
    exp_q.push_back(ev);
endfunction

// ======================================================================
// instruction-level model, runs the program to HALT ahead of the DUT
// ======================================================================
function automatic void run_model();
    word_t r [0:7];
    psw_t  f;
    word_t pc;
    word_t op;
    word_t s;
    word_t d;
    word_t res;
    int    sv;
    logic  taken;
    logic  done;
    for (int i = 0; i < 8; i++) r[i] = '0;
    f    = '0;
    pc   = BOOT_ADDR;
    done = 1'b0;
    exp_q.delete();
    for (int step = 0; step < 1000 && !done; step++) begin
        op = mem[word_index(pc)];
        add_event(EV_FETCH, op == RESET_OP, pc, '0);
        pc = pc + 16'd2;
        if (op == HALT_OP) begin
            done = 1'b1;
        end else if (op[15:8] inside {BR_OP[15:8], BNE_OP[15:8], BEQ_OP[15:8]}) begin
            taken = (op[15:8] == BR_OP[15:8]) ||
                    (op[15:8] == BNE_OP[15:8] && !f.z) ||
                    (op[15:8] == BEQ_OP[15:8] && f.z);
            if (taken) pc = pc + {{7{op[7]}}, op[7:0], 1'b0};
        end else if (op != RESET_OP) begin
            if (op[11:9] == 3'd2) begin
                add_event(EV_READ, 1'b0, pc, '0);   // immediate word
                s  = mem[word_index(pc)];
                pc = pc + 16'd2;
            end else begin
                s = r[op[8:6]];
            end
            d = r[op[2:0]];
            case ({op[15:12], 12'o0})
                ADD_OP: begin
                    res = d + s;
                    f.c = (int'(d) + int'(s)) > 65535;
                    sv  = int'($signed(d)) + int'($signed(s));
                end
                SUB_OP: begin
                    res = d - s;
                    f.c = s > d;                    // borrow
                    sv  = int'($signed(d)) - int'($signed(s));
                end
                CMP_OP: begin
                    res = s - d;
                    f.c = d > s;
                    sv  = int'($signed(s)) - int'($signed(d));
                end
                default: begin
                    res = s;                        // MOV keeps C
                    sv  = 0;
                end
            endcase
            f.v = (sv > 32767) || (sv < -32768);
            f.n = res[15];
            f.z = (res == '0);
            if (op[5:3] == 3'd1) begin
                add_event(EV_STORE, 1'b0, r[op[2:0]], res);
            end else if ({op[15:12], 12'o0} != CMP_OP) begin
                r[op[2:0]] = res;
            end
        end
    end
endfunction

//--- testbench/tb_cpu_core.sv
// ======================================================================
// Testbench of the core with a random program checked bus cycle by bus
// cycle against the reference model, under random reply delays and ce gaps
// ======================================================================

module tb_cpu_core;
    import cpu_types_pkg::*;

    localparam word_t       BOOT_ADDR   = 16'o100000;
    localparam int unsigned INIT_CYCLES = 10;
    localparam int          CLK_HALF    = 50;
    localparam int          DRIVE_DLY   = 5;
    localparam int          HALT_WAIT   = 50;
    localparam logic [31:0] SEED        = 32'h0db8_9545;

    localparam logic [1:0] EV_FETCH = 2'd0;
    localparam logic [1:0] EV_READ  = 2'd1;
    localparam logic [1:0] EV_STORE = 2'd2;

    typedef struct packed {
        logic [1:0] kind;
        logic       is_reset;   // fetch of the RESET opcode
        word_t      addr;
        word_t      data;
    } bus_evt_t;

    logic        clk;
    logic        rst_n_i;
    logic        ce_i;
    logic        rply_i;
    word_t       data_i;
    word_t       addr_o;
    word_t       data_o;
    logic        din_o;
    logic        dout_o;
    logic        ifetch_o;
    logic        init_o;
    logic        halt_o;

    word_t       mem [0:255];
    logic [31:0] lfsr_q;
    int unsigned wr_idx;
    int          n_instr;
    logic        prog_ready;
    bus_evt_t    exp_q [$];

    logic        armed;
    logic [1:0]  reply_wait;
    logic        strobe_q;
    word_t       held_addr;
    word_t       held_data;
    logic        reset_done;
    logic        halted;
    logic        init_q;
    int          init_cnt;
    int          init_rises;

    `include "cpu_ref_model.svh"

    cpu_core #(
        .BOOT_ADDR   (BOOT_ADDR),
        .INIT_CYCLES (INIT_CYCLES)
    ) cpu_core_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .ce_i     (ce_i),
        .rply_i   (rply_i),
        .data_i   (data_i),
        .addr_o   (addr_o),
        .data_o   (data_o),
        .din_o    (din_o),
        .dout_o   (dout_o),
        .ifetch_o (ifetch_o),
        .init_o   (init_o),
        .halt_o   (halt_o)
    );

    always #CLK_HALF clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got == exp) else
            report_fail($sformatf("CHECK FAILED %s expected %h got %h", name, exp, got));
    endtask

    // ce low about a quarter of the time and reply after 0-3 cycles
    task automatic drive_inputs();
        ce_i = (take_bits(2) != 0);
        if (!(din_o || dout_o)) begin
            rply_i = 1'b0;
            armed  = 1'b0;
        end else if (!rply_i) begin
            if (!armed) begin
                armed      = 1'b1;
                reply_wait = 2'(take_bits(2));
            end else if (reply_wait != 0) begin
                reply_wait--;
            end
            if (reply_wait == 0) begin
                rply_i = 1'b1;
                data_i = mem[word_index(addr_o)];
            end
        end
    endtask

    // ==================================================================
    // bus monitor sampled mid-cycle when everything is settled
    // ==================================================================
    task automatic watch_bus();
        logic       strobe;
        logic [1:0] kind;
        bus_evt_t   ev;
        strobe = din_o || dout_o;
        assert (!(halted && strobe)) else report_fail("bus cycle started after halt_o");
        if (strobe && strobe_q) begin
            check_word("addr_o", addr_o, held_addr);
            if (dout_o) check_word("data_o", data_o, held_data);
        end
        held_addr = addr_o;
        held_data = data_o;
        strobe_q  = strobe;
        if (strobe && rply_i && ce_i) begin   // transfer ends at next edge
            kind = dout_o ? EV_STORE : (ifetch_o ? EV_FETCH : EV_READ);
            assert (exp_q.size() != 0) else
                report_fail("bus cycle beyond the end of the program");
            ev = exp_q.pop_front();
            assert (kind == ev.kind) else
                report_fail($sformatf("CHECK FAILED bus_kind expected %h got %h",
                                      ev.kind, kind));
            check_word("addr_o", addr_o, ev.addr);
            if (kind == EV_STORE) begin
                check_word("data_o", data_o, ev.data);
                mem[word_index(addr_o)] = data_o;
            end
            if (ev.is_reset) reset_done = 1'b1;
        end
        if (halt_o && !halted) begin
            assert (exp_q.size() == 0) else
                report_fail("halt_o rose before the program ended");
            halted = 1'b1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n_i) begin
            if ($time > CLK_HALF) begin
                assert (!din_o && !dout_o && !ifetch_o && !init_o && !halt_o) else
                    report_fail("bus strobe, ifetch_o, init_o or halt_o high during reset");
            end
        end else begin
            watch_bus();
            if (init_o) begin
                assert (reset_done) else
                    report_fail("init_o rose before the RESET instruction");
                if (!init_q) init_rises++;
                if (ce_i) init_cnt++;
            end
            init_q = init_o;
        end
    end

    initial begin
        wait (prog_ready);
        repeat (n_instr * 40 + HALT_WAIT + 10) @(posedge clk);
        report_fail("watchdog expired before the program reached HALT");
    end

    initial begin
        clk        = 1'b0;
        rst_n_i    = 1'b0;
        ce_i       = 1'b1;
        rply_i     = 1'b0;
        data_i     = '0;
        lfsr_q     = SEED;
        prog_ready = 1'b0;
        armed      = 1'b0;
        reply_wait = '0;
        strobe_q   = 1'b0;
        held_addr  = '0;
        held_data  = '0;
        reset_done = 1'b0;
        halted     = 1'b0;
        init_q     = 1'b0;
        init_cnt   = 0;
        init_rises = 0;
        gen_program();
        run_model();
        prog_ready = 1'b1;

        repeat (3) @(posedge clk);
        #DRIVE_DLY rst_n_i = 1'b1;
        while (!halted) begin
            @(posedge clk);
            #DRIVE_DLY drive_inputs();
        end
        repeat (HALT_WAIT) begin   // core must stay quiet
            @(posedge clk);
            #DRIVE_DLY drive_inputs();
        end

        check_word("pending_cycles", word_t'(exp_q.size()), 16'd0);
        check_word("init_cycles", word_t'(init_cnt), word_t'(INIT_CYCLES));
        check_word("init_rises", word_t'(init_rises), 16'd1);
        assert (halt_o) else report_fail("halt_o fell after the HALT instruction");
        $display("STATUS: PASS");
        $finish;
    end

endmodule
